// ==== verilog/gpio_pkg.sv ====
package gpio_pkg;

  // register bus widths
  localparam int GPIO_AW = 6;
  localparam int GPIO_DW = 32;
  localparam int GPIO_BW = GPIO_DW / 8;

  // pin count, one register bit per pin
  localparam int GPIO_N = 32;

  // byte offsets of the register map
  // 0x20 and 0x24 are left unmapped
  typedef enum logic [GPIO_AW-1:0] {
    REG_INTR_STATE       = 6'h00,
    REG_INTR_ENABLE      = 6'h04,
    REG_INTR_TEST        = 6'h08,
    REG_DATA_IN          = 6'h0C,
    REG_DIRECT_OUT       = 6'h10,
    REG_MASKED_OUT_LOWER = 6'h14,
    REG_MASKED_OUT_UPPER = 6'h18,
    REG_DIRECT_OE        = 6'h1C,
    REG_INTR_EN_RISING   = 6'h28,
    REG_INTR_EN_FALLING  = 6'h2C,
    REG_INTR_EN_LVLHIGH  = 6'h30,
    REG_INTR_EN_LVLLOW   = 6'h34
  } gpio_reg_e;

  // returned on a read from an unmapped offset
  localparam logic [GPIO_DW-1:0] GPIO_RDATA_MISS = '1;

endpackage

// ==== verilog/gpio_reg_if.sv ====
module gpio_reg_if (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         reg_we_i,
  input  logic                         reg_re_i,
  input  logic [gpio_pkg::GPIO_AW-1:0] reg_addr_i,
  input  logic [gpio_pkg::GPIO_DW-1:0] reg_wdata_i,
  input  logic [gpio_pkg::GPIO_BW-1:0] reg_be_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  out_q_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  oe_q_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  data_in_q_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  intr_state_q_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  intr_enable_q_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  en_rising_q_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  en_falling_q_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  en_lvlhigh_q_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  en_lvllow_q_i,
  output logic                         wr_o,
  output gpio_pkg::gpio_reg_e          sel_o,
  output logic [gpio_pkg::GPIO_DW-1:0] wdata_o,
  output logic                         reg_ack_o,
  output logic [gpio_pkg::GPIO_DW-1:0] reg_rdata_o,
  output logic                         reg_error_o
);

  import gpio_pkg::*;

  localparam int Half = GPIO_N / 2;

  logic               addr_hit;
  logic               addr_miss;
  logic               wr_err;
  logic               error;
  logic [GPIO_DW-1:0] rdata_next;

  // the offset itself is the select, blocks decode their own registers
  assign sel_o   = gpio_reg_e'(reg_addr_i);
  assign wdata_o = reg_wdata_i;

  always_comb begin
    case (sel_o)
      REG_INTR_STATE, REG_INTR_ENABLE, REG_INTR_TEST, REG_DATA_IN,
      REG_DIRECT_OUT, REG_MASKED_OUT_LOWER, REG_MASKED_OUT_UPPER,
      REG_DIRECT_OE, REG_INTR_EN_RISING, REG_INTR_EN_FALLING,
      REG_INTR_EN_LVLHIGH, REG_INTR_EN_LVLLOW: addr_hit = 1'b1;
      default: addr_hit = 1'b0;
    endcase
  end

  assign addr_miss = (reg_we_i || reg_re_i) && !addr_hit;
  // full-word writes only, data in is read-only
  assign wr_err    = reg_we_i && ((reg_be_i != '1) || (sel_o == REG_DATA_IN));
  assign error     = addr_miss || wr_err;
  assign wr_o      = reg_we_i && !error;

  always_comb begin
    case (sel_o)
      REG_INTR_STATE:       rdata_next = intr_state_q_i;
      REG_INTR_ENABLE:      rdata_next = intr_enable_q_i;
      REG_INTR_TEST:        rdata_next = '0;
      REG_DATA_IN:          rdata_next = data_in_q_i;
      REG_DIRECT_OUT:       rdata_next = out_q_i;
      REG_MASKED_OUT_LOWER: rdata_next = {{Half{1'b0}}, out_q_i[Half-1:0]};
      REG_MASKED_OUT_UPPER: rdata_next = {{Half{1'b0}}, out_q_i[GPIO_N-1:Half]};
      REG_DIRECT_OE:        rdata_next = oe_q_i;
      REG_INTR_EN_RISING:   rdata_next = en_rising_q_i;
      REG_INTR_EN_FALLING:  rdata_next = en_falling_q_i;
      REG_INTR_EN_LVLHIGH:  rdata_next = en_lvlhigh_q_i;
      REG_INTR_EN_LVLLOW:   rdata_next = en_lvllow_q_i;
      default:              rdata_next = GPIO_RDATA_MISS;
    endcase
  end

  // response one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      reg_ack_o   <= 1'b0;
      reg_error_o <= 1'b0;
    end else begin
      reg_ack_o   <= reg_we_i || reg_re_i;
      reg_error_o <= error;
    end
  end

  always_ff @(posedge clk_i) begin
    reg_rdata_o <= reg_re_i ? rdata_next : '0;
  end

  a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(reg_we_i && reg_re_i));

  a_ack_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (reg_we_i || reg_re_i) |=> reg_ack_o);

endmodule

// ==== verilog/gpio_out_ctrl.sv ====
module gpio_out_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         wr_i,
  input  gpio_pkg::gpio_reg_e          sel_i,
  input  logic [gpio_pkg::GPIO_DW-1:0] wdata_i,
  output logic [gpio_pkg::GPIO_N-1:0]  gpio_o,
  output logic [gpio_pkg::GPIO_N-1:0]  gpio_oe_o,
  output logic [gpio_pkg::GPIO_N-1:0]  out_q_o,
  output logic [gpio_pkg::GPIO_N-1:0]  oe_q_o
);

  import gpio_pkg::*;

  localparam int Half = GPIO_N / 2;

  logic [GPIO_N-1:0] out_q;
  logic [GPIO_N-1:0] oe_q;
  logic [Half-1:0]   wr_mask;
  logic [Half-1:0]   wr_data;

  // masked layout: mask in the upper half, data in the lower half
  assign wr_mask = wdata_i[GPIO_DW-1:Half];
  assign wr_data = wdata_i[Half-1:0];

  // keep bits where the mask is clear
  function automatic logic [Half-1:0] merge_half(
    input logic [Half-1:0] old_bits,
    input logic [Half-1:0] mask,
    input logic [Half-1:0] data
  );
    return (old_bits & ~mask) | (data & mask);
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else if (wr_i) begin
      case (sel_i)
        REG_DIRECT_OUT:       out_q <= wdata_i;
        REG_MASKED_OUT_LOWER: out_q[Half-1:0] <= merge_half(out_q[Half-1:0], wr_mask, wr_data);
        REG_MASKED_OUT_UPPER: begin
          out_q[GPIO_N-1:Half] <= merge_half(out_q[GPIO_N-1:Half], wr_mask, wr_data);
        end
        REG_DIRECT_OE:        oe_q <= wdata_i;
        default: begin
          // other offsets belong to the interrupt block
        end
      endcase
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign out_q_o   = out_q;
  assign oe_q_o    = oe_q;

  // pins only move on an accepted write
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !wr_i |=> ($stable(gpio_o) && $stable(gpio_oe_o)));

endmodule

// ==== verilog/gpio_intr_ctrl.sv ====
module gpio_intr_ctrl #(
  parameter int SyncStages = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  gpio_i,
  input  logic                         wr_i,
  input  gpio_pkg::gpio_reg_e          sel_i,
  input  logic [gpio_pkg::GPIO_DW-1:0] wdata_i,
  output logic [gpio_pkg::GPIO_N-1:0]  intr_o,
  output logic [gpio_pkg::GPIO_N-1:0]  data_in_q_o,
  output logic [gpio_pkg::GPIO_N-1:0]  intr_state_q_o,
  output logic [gpio_pkg::GPIO_N-1:0]  intr_enable_q_o,
  output logic [gpio_pkg::GPIO_N-1:0]  en_rising_q_o,
  output logic [gpio_pkg::GPIO_N-1:0]  en_falling_q_o,
  output logic [gpio_pkg::GPIO_N-1:0]  en_lvlhigh_q_o,
  output logic [gpio_pkg::GPIO_N-1:0]  en_lvllow_q_o
);

  import gpio_pkg::*;

  logic [SyncStages-1:0][GPIO_N-1:0] sync_q;
  logic [GPIO_N-1:0] data_in;
  logic [GPIO_N-1:0] prev_q;
  logic [GPIO_N-1:0] rising;
  logic [GPIO_N-1:0] falling;
  logic [GPIO_N-1:0] event_set;
  logic [GPIO_N-1:0] test_set;
  logic [GPIO_N-1:0] w1c_clr;
  logic [GPIO_N-1:0] state_q;
  logic [GPIO_N-1:0] enable_q;
  logic [GPIO_N-1:0] en_rising_q;
  logic [GPIO_N-1:0] en_falling_q;
  logic [GPIO_N-1:0] en_lvlhigh_q;
  logic [GPIO_N-1:0] en_lvllow_q;

  // input synchronizer, stage 0 takes the raw pins
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      sync_q[0] <= gpio_i;
      for (int i = 1; i < SyncStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      prev_q <= data_in;
    end
  end

  assign data_in = sync_q[SyncStages-1];

  // edges against the previous synchronized sample
  assign rising  = data_in & ~prev_q;
  assign falling = ~data_in & prev_q;

  assign event_set = (rising & en_rising_q) | (falling & en_falling_q) |
                     (data_in & en_lvlhigh_q) | (~data_in & en_lvllow_q);

  assign test_set = (wr_i && sel_i == REG_INTR_TEST) ? wdata_i : '0;
  assign w1c_clr  = (wr_i && sel_i == REG_INTR_STATE) ? wdata_i : '0;

  // set wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= '0;
    end else begin
      state_q <= (state_q & ~w1c_clr) | event_set | test_set;
    end
  end

  // plain read/write control registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q     <= '0;
      en_rising_q  <= '0;
      en_falling_q <= '0;
      en_lvlhigh_q <= '0;
      en_lvllow_q  <= '0;
    end else if (wr_i) begin
      case (sel_i)
        REG_INTR_ENABLE:     enable_q     <= wdata_i;
        REG_INTR_EN_RISING:  en_rising_q  <= wdata_i;
        REG_INTR_EN_FALLING: en_falling_q <= wdata_i;
        REG_INTR_EN_LVLHIGH: en_lvlhigh_q <= wdata_i;
        REG_INTR_EN_LVLLOW:  en_lvllow_q  <= wdata_i;
        default: begin
          // state and test handled above, outputs elsewhere
        end
      endcase
    end
  end

  assign intr_o          = state_q & enable_q;
  assign data_in_q_o     = data_in;
  assign intr_state_q_o  = state_q;
  assign intr_enable_q_o = enable_q;
  assign en_rising_q_o   = en_rising_q;
  assign en_falling_q_o  = en_falling_q;
  assign en_lvlhigh_q_o  = en_lvlhigh_q;
  assign en_lvllow_q_o   = en_lvllow_q;

  // masked lines never reach the interrupt output
  a_intr_masked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (intr_o & ~intr_enable_q_o) == '0);

endmodule

// ==== verilog/gpio_top.sv ====
module gpio_top #(
  parameter int SyncStages = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         reg_we_i,
  input  logic                         reg_re_i,
  input  logic [gpio_pkg::GPIO_AW-1:0] reg_addr_i,
  input  logic [gpio_pkg::GPIO_DW-1:0] reg_wdata_i,
  input  logic [gpio_pkg::GPIO_BW-1:0] reg_be_i,
  input  logic [gpio_pkg::GPIO_N-1:0]  gpio_i,
  output logic                         reg_ack_o,
  output logic [gpio_pkg::GPIO_DW-1:0] reg_rdata_o,
  output logic                         reg_error_o,
  output logic [gpio_pkg::GPIO_N-1:0]  gpio_o,
  output logic [gpio_pkg::GPIO_N-1:0]  gpio_oe_o,
  output logic [gpio_pkg::GPIO_N-1:0]  intr_o
);

  import gpio_pkg::*;

  logic               wr;
  gpio_reg_e          sel;
  logic [GPIO_DW-1:0] wdata;
  logic [GPIO_N-1:0]  out_q;
  logic [GPIO_N-1:0]  oe_q;
  logic [GPIO_N-1:0]  data_in_q;
  logic [GPIO_N-1:0]  intr_state_q;
  logic [GPIO_N-1:0]  intr_enable_q;
  logic [GPIO_N-1:0]  en_rising_q;
  logic [GPIO_N-1:0]  en_falling_q;
  logic [GPIO_N-1:0]  en_lvlhigh_q;
  logic [GPIO_N-1:0]  en_lvllow_q;

  gpio_reg_if u_reg_if (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .reg_we_i        (reg_we_i),
    .reg_re_i        (reg_re_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_be_i        (reg_be_i),
    .out_q_i         (out_q),
    .oe_q_i          (oe_q),
    .data_in_q_i     (data_in_q),
    .intr_state_q_i  (intr_state_q),
    .intr_enable_q_i (intr_enable_q),
    .en_rising_q_i   (en_rising_q),
    .en_falling_q_i  (en_falling_q),
    .en_lvlhigh_q_i  (en_lvlhigh_q),
    .en_lvllow_q_i   (en_lvllow_q),
    .wr_o            (wr),
    .sel_o           (sel),
    .wdata_o         (wdata),
    .reg_ack_o       (reg_ack_o),
    .reg_rdata_o     (reg_rdata_o),
    .reg_error_o     (reg_error_o)
  );

  gpio_out_ctrl u_out_ctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr_i      (wr),
    .sel_i     (sel),
    .wdata_i   (wdata),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .out_q_o   (out_q),
    .oe_q_o    (oe_q)
  );

  gpio_intr_ctrl #(
    .SyncStages (SyncStages)
  ) u_intr_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .gpio_i          (gpio_i),
    .wr_i            (wr),
    .sel_i           (sel),
    .wdata_i         (wdata),
    .intr_o          (intr_o),
    .data_in_q_o     (data_in_q),
    .intr_state_q_o  (intr_state_q),
    .intr_enable_q_o (intr_enable_q),
    .en_rising_q_o   (en_rising_q),
    .en_falling_q_o  (en_falling_q),
    .en_lvlhigh_q_o  (en_lvlhigh_q),
    .en_lvllow_q_o   (en_lvllow_q)
  );

endmodule

// ==== tests/gpio_tb.sv ====
module gpio_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import gpio_pkg::*;

  localparam int SyncStages  = 2;
  localparam int ClkPeriodNs = 10;
  localparam int NumTests    = 5;
  // each test gets 200 clock cycles
  localparam int TimeoutNs   = NumTests * 200 * ClkPeriodNs;

  logic               clk_i;
  logic               rst_n_i;
  logic               reg_we_i;
  logic               reg_re_i;
  logic [GPIO_AW-1:0] reg_addr_i;
  logic [GPIO_DW-1:0] reg_wdata_i;
  logic [GPIO_BW-1:0] reg_be_i;
  logic [GPIO_N-1:0]  gpio_i;
  logic               reg_ack_o;
  logic [GPIO_DW-1:0] reg_rdata_o;
  logic               reg_error_o;
  logic [GPIO_N-1:0]  gpio_o;
  logic [GPIO_N-1:0]  gpio_oe_o;
  logic [GPIO_N-1:0]  intr_o;

  int unsigned       seed;
  int                errors;
  // expected output and output-enable registers
  logic [GPIO_N-1:0] exp_out;
  logic [GPIO_N-1:0] exp_oe;

  gpio_top #(
    .SyncStages (SyncStages)
  ) dut0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_be_i    (reg_be_i),
    .gpio_i      (gpio_i),
    .reg_ack_o   (reg_ack_o),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .gpio_o      (gpio_o),
    .gpio_oe_o   (gpio_oe_o),
    .intr_o      (intr_o)
  );

  always #(ClkPeriodNs / 2) clk_i = ~clk_i;

  task automatic check(input logic [GPIO_DW-1:0] got, input logic [GPIO_DW-1:0] exp,
                       input string msg);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic bus_cycle(input logic is_write, input logic [GPIO_AW-1:0] addr,
                           input logic [GPIO_DW-1:0] wdata, input logic [GPIO_BW-1:0] be,
                           output logic [GPIO_DW-1:0] rdata, output logic err);
    int wait_cycles;
    wait_cycles = 0;
    reg_we_i    = is_write;
    reg_re_i    = !is_write;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    reg_be_i    = be;
    @(negedge clk_i);
    reg_we_i = 1'b0;
    reg_re_i = 1'b0;
    while (!reg_ack_o && wait_cycles < 4) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    rdata = reg_rdata_o;
    err   = reg_error_o;
    if (!reg_ack_o) begin
      $display("no ack from the DUT for the access to offset %h at %0d ns", addr, $time);
      errors++;
    end else begin
      check(wait_cycles, 0, "extra cycles before ack");
    end
    @(negedge clk_i);
    check(reg_ack_o, 1'b0, "ack held longer than one cycle");
  endtask

  task automatic bus_write(input logic [GPIO_AW-1:0] addr, input logic [GPIO_DW-1:0] wdata,
                           input logic [GPIO_BW-1:0] be, output logic err);
    logic [GPIO_DW-1:0] unused;
    bus_cycle(1'b1, addr, wdata, be, unused, err);
  endtask

  task automatic bus_read(input logic [GPIO_AW-1:0] addr, output logic [GPIO_DW-1:0] rdata,
                          output logic err);
    bus_cycle(1'b0, addr, '0, '0, rdata, err);
  endtask

  task automatic write_reg(input logic [GPIO_AW-1:0] addr, input logic [GPIO_DW-1:0] data,
                           input string msg);
    logic err;
    bus_write(addr, data, '1, err);
    check(err, 1'b0, {msg, " error flag"});
  endtask

  task automatic read_expect(input logic [GPIO_AW-1:0] addr, input logic [GPIO_DW-1:0] exp,
                             input string msg);
    logic [GPIO_DW-1:0] rdata;
    logic               err;
    bus_read(addr, rdata, err);
    check(err, 1'b0, {msg, " error flag"});
    check(rdata, exp, msg);
  endtask

  task automatic settle_inputs();
    repeat (SyncStages + 3) @(negedge clk_i);
  endtask

  task automatic drive_pins(input logic [GPIO_N-1:0] value);
    gpio_i = value;
    settle_inputs();
  endtask

  task automatic clear_state();
    write_reg(REG_INTR_STATE, '1, "state clear");
    read_expect(REG_INTR_STATE, '0, "state after clear");
    check(intr_o, '0, "intr_o after clear");
  endtask

  task automatic reset_values();
    gpio_reg_e regs [12];
    regs = '{REG_INTR_STATE, REG_INTR_ENABLE, REG_INTR_TEST, REG_DATA_IN,
             REG_DIRECT_OUT, REG_MASKED_OUT_LOWER, REG_MASKED_OUT_UPPER, REG_DIRECT_OE,
             REG_INTR_EN_RISING, REG_INTR_EN_FALLING, REG_INTR_EN_LVLHIGH,
             REG_INTR_EN_LVLLOW};
    check(gpio_o, '0, "gpio_o after reset");
    check(gpio_oe_o, '0, "gpio_oe_o after reset");
    check(intr_o, '0, "intr_o after reset");
    foreach (regs[i]) begin
      read_expect(regs[i], '0, $sformatf("%s after reset", regs[i].name()));
    end
  endtask

  task automatic direct_output();
    logic [GPIO_DW-1:0] value;
    repeat (4) begin
      value = $urandom;
      write_reg(REG_DIRECT_OUT, value, "direct out write");
      exp_out = value;
      check(gpio_o, exp_out, "gpio_o after direct write");
      read_expect(REG_DIRECT_OUT, exp_out, "direct out readback");
      value = $urandom;
      write_reg(REG_DIRECT_OE, value, "direct oe write");
      exp_oe = value;
      check(gpio_oe_o, exp_oe, "gpio_oe_o after direct write");
      read_expect(REG_DIRECT_OE, exp_oe, "direct oe readback");
    end
  endtask

  task automatic masked_output();
    logic [GPIO_DW-1:0] word;
    logic [15:0]        mask;
    logic [15:0]        data;
    int                 base;
    repeat (8) begin
      word = $urandom;
      mask = word[31:16];
      data = word[15:0];
      base = ($urandom % 2) * 16;
      // only bits with a set mask bit take the new data
      for (int b = 0; b < 16; b++) begin
        if (mask[b]) begin
          exp_out[base+b] = data[b];
        end
      end
      if (base == 16) begin
        write_reg(REG_MASKED_OUT_UPPER, word, "masked upper write");
        read_expect(REG_MASKED_OUT_UPPER, {16'h0, exp_out[31:16]}, "masked upper readback");
      end else begin
        write_reg(REG_MASKED_OUT_LOWER, word, "masked lower write");
        read_expect(REG_MASKED_OUT_LOWER, {16'h0, exp_out[15:0]}, "masked lower readback");
      end
      check(gpio_o, exp_out, "gpio_o after masked write");
      read_expect(REG_DIRECT_OUT, exp_out, "direct out after masked write");
    end
  endtask

  task automatic input_interrupts();
    logic [GPIO_N-1:0] pins;
    logic [GPIO_N-1:0] prev;
    logic [GPIO_N-1:0] trig;
    logic [GPIO_N-1:0] en;
    logic [GPIO_N-1:0] test_bits;
    logic [GPIO_N-1:0] clr_bits;
    pins = $urandom;
    drive_pins(pins);
    read_expect(REG_DATA_IN, pins, "data in");
    read_expect(REG_INTR_STATE, '0, "state with no trigger enabled");

    // rising edges from an all-low start
    drive_pins('0);
    trig = $urandom;
    write_reg(REG_INTR_EN_RISING, trig, "rising enable write");
    pins = $urandom;
    drive_pins(pins);
    read_expect(REG_INTR_STATE, pins & trig, "state after rising edges");
    en = $urandom;
    write_reg(REG_INTR_ENABLE, en, "interrupt enable write");
    read_expect(REG_INTR_ENABLE, en, "interrupt enable readback");
    check(intr_o, pins & trig & en, "intr_o after rising edges");
    write_reg(REG_INTR_EN_RISING, '0, "rising disable");
    clear_state();

    prev = pins;
    trig = $urandom;
    write_reg(REG_INTR_EN_FALLING, trig, "falling enable write");
    pins = $urandom;
    drive_pins(pins);
    read_expect(REG_INTR_STATE, prev & ~pins & trig, "state after falling edges");
    check(intr_o, prev & ~pins & trig & en, "intr_o after falling edges");
    write_reg(REG_INTR_EN_FALLING, '0, "falling disable");
    clear_state();

    // a held level sets the bit again in the clearing cycle
    trig = $urandom;
    write_reg(REG_INTR_EN_LVLHIGH, trig, "level high enable write");
    settle_inputs();
    read_expect(REG_INTR_STATE, pins & trig, "state with level high");
    write_reg(REG_INTR_STATE, '1, "clear under level high");
    read_expect(REG_INTR_STATE, pins & trig, "level high state after clear");
    write_reg(REG_INTR_EN_LVLHIGH, '0, "level high disable");
    clear_state();

    trig = $urandom;
    write_reg(REG_INTR_EN_LVLLOW, trig, "level low enable write");
    settle_inputs();
    read_expect(REG_INTR_STATE, ~pins & trig, "state with level low");
    check(intr_o, ~pins & trig & en, "intr_o with level low");
    write_reg(REG_INTR_EN_LVLLOW, '0, "level low disable");
    clear_state();

    test_bits = $urandom;
    write_reg(REG_INTR_TEST, test_bits, "test write");
    read_expect(REG_INTR_STATE, test_bits, "state after test write");
    check(intr_o, test_bits & en, "intr_o after test write");
    read_expect(REG_INTR_TEST, '0, "test register readback");
    clr_bits = $urandom;
    write_reg(REG_INTR_STATE, clr_bits, "partial clear");
    read_expect(REG_INTR_STATE, test_bits & ~clr_bits, "state after partial clear");
    clear_state();
  endtask

  task automatic error_responses();
    logic [GPIO_DW-1:0] rdata;
    logic               err;
    bus_read(6'h20, rdata, err);
    check(err, 1'b1, "error flag on unmapped read 0x20");
    check(rdata, GPIO_RDATA_MISS, "data on unmapped read 0x20");
    bus_read(6'h3C, rdata, err);
    check(err, 1'b1, "error flag on unmapped read 0x3c");
    check(rdata, GPIO_RDATA_MISS, "data on unmapped read 0x3c");

    bus_write(REG_DIRECT_OUT, ~exp_out, 4'b0111, err);
    check(err, 1'b1, "error flag on partial write to direct out");
    check(gpio_o, exp_out, "gpio_o after partial write");
    read_expect(REG_DIRECT_OUT, exp_out, "direct out after partial write");
    bus_write(REG_DIRECT_OE, ~exp_oe, 4'b1110, err);
    check(err, 1'b1, "error flag on partial write to direct oe");
    check(gpio_oe_o, exp_oe, "gpio_oe_o after partial write");

    bus_write(REG_DATA_IN, $urandom, '1, err);
    check(err, 1'b1, "error flag on write to data in");
    read_expect(REG_DIRECT_OUT, exp_out, "direct out after data in write");
    read_expect(REG_DIRECT_OE, exp_oe, "direct oe after data in write");
    read_expect(REG_INTR_STATE, '0, "state after data in write");
    bus_write(6'h24, $urandom, '1, err);
    check(err, 1'b1, "error flag on unmapped write 0x24");
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    reg_we_i    = 1'b0;
    reg_re_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    reg_be_i    = '0;
    gpio_i      = '0;
    errors      = 0;
    exp_out     = '0;
    exp_oe      = '0;
    seed        = 32'hf8a5;
    void'($urandom(seed));
    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    reset_values();
    direct_output();
    masked_output();
    input_interrupts();
    error_responses();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TimeoutNs);
    $display("timeout: the tests did not finish within %0d ns", TimeoutNs);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== files.f ====
verilog/gpio_pkg.sv
verilog/gpio_reg_if.sv
verilog/gpio_out_ctrl.sv
verilog/gpio_intr_ctrl.sv
verilog/gpio_top.sv
tests/gpio_tb.sv

// ==== Bender.yml ====
package:
  name: gpio

sources:
  - verilog/gpio_pkg.sv
  - verilog/gpio_reg_if.sv
  - verilog/gpio_out_ctrl.sv
  - verilog/gpio_intr_ctrl.sv
  - verilog/gpio_top.sv
  - target: test
    files:
      - tests/gpio_tb.sv
